// File: project.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/ctrlUnit.sv
rtl/cpuFsm.sv
rtl/pcCounter.sv
rtl/regFile.sv
rtl/alu.sv
rtl/memory.sv
rtl/cpuTop.sv
verification/cpuTb.sv

// File: rtl/alu.sv
`include "cpuDefs.svh"

module alu (
	input  logic               clk,
	input  logic               rstN,
	input  cpuPkg::instrT      instr,
	input  logic               aluOp,
	input  logic               aluImm,
	input  logic               pcs,
	input  logic               llb,
	input  logic               lhb,
	input  logic               flagWe,
	input  logic [`DATA_W-1:0] opA,
	input  logic [`DATA_W-1:0] opB,
	input  logic [`DATA_W-1:0] pc,
	output logic [`DATA_W-1:0] result,
	output logic               flagZ,
	output logic               flagV,
	output logic               flagN
);

	localparam int W = `DATA_W;
	localparam logic [W-1:0] MaxPos = {1'b0, {(W-1){1'b1}}};
	localparam logic [W-1:0] MaxNeg = {1'b1, {(W-1){1'b0}}};

	logic [W-1:0]        sum;
	logic [W-1:0]        diff;
	logic [W-1:0]        addSat;
	logic [W-1:0]        subSat;
	logic [W-1:0]        redRes;
	logic [W-1:0]        paddRes;
	logic [W-1:0]        effAddr;
	logic                addOvf;
	logic                subOvf;
	logic signed [9:0]   redSum;
	logic [3:0]          shAmt;

	assign sum    = opA + opB;
	assign diff   = opA - opB;
	assign addOvf = (opA[W-1] == opB[W-1]) && (sum[W-1] != opA[W-1]);
	assign subOvf = (opA[W-1] != opB[W-1]) && (diff[W-1] != opA[W-1]);
	assign addSat = addOvf ? (opA[W-1] ? MaxNeg : MaxPos) : sum;
	assign subSat = subOvf ? (opA[W-1] ? MaxNeg : MaxPos) : diff;

	assign redSum = $signed(opA[15:8]) + $signed(opA[7:0]) + $signed(opB[15:8]) + $signed(opB[7:0]);
	assign redRes = {{(W-10){redSum[9]}}, redSum};

	// Shift count comes from the rt field for the immediate forms
	assign shAmt = aluImm ? instr.rType.rt : opB[3:0];

	// Word offset in rt scaled to bytes
	assign effAddr = opA + {{(W-5){instr.rType.rt[3]}}, instr.rType.rt, 1'b0};

	always_comb begin
		logic [4:0] nibSum;
		for (int i = 0; i < W / 4; i++) begin
			nibSum = {opA[4*i+3], opA[4*i +: 4]} + {opB[4*i+3], opB[4*i +: 4]};
			if (nibSum[4] != nibSum[3])
				paddRes[4*i +: 4] = nibSum[4] ? 4'h8 : 4'h7;
			else
				paddRes[4*i +: 4] = nibSum[3:0];
		end
	end

	always_comb begin
		if (aluOp) begin
			case (instr.rType.opcode)
				cpuPkg::ADD:    result = addSat;
				cpuPkg::SUB:    result = subSat;
				cpuPkg::RED:    result = redRes;
				cpuPkg::XOR:    result = opA ^ opB;
				cpuPkg::SLL:    result = opA << shAmt;
				cpuPkg::SRA:    result = $signed(opA) >>> shAmt;
				cpuPkg::ROR:    result = (opA >> shAmt) | (opA << (W - shAmt));
				cpuPkg::PADDSB: result = paddRes;
				default:        result = effAddr;
			endcase
		end else if (llb) begin
			result = {opB[W-1:8], instr.iType.imm};
		end else if (lhb) begin
			result = {instr.iType.imm, opB[7:0]};
		end else if (pcs) begin
			result = pc;
		end else begin
			result = effAddr;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flagZ <= 1'b0;
			flagV <= 1'b0;
			flagN <= 1'b0;
		end else if (flagWe) begin
			case (instr.rType.opcode)
				cpuPkg::ADD, cpuPkg::SUB: begin
					flagZ <= (result == '0);
					flagV <= (instr.rType.opcode == cpuPkg::ADD) ? addOvf : subOvf;
					flagN <= result[W-1];
				end
				cpuPkg::XOR, cpuPkg::SLL, cpuPkg::SRA, cpuPkg::ROR: begin
					flagZ <= (result == '0);
				end
				// RED and PADDSB leave the flags alone
				default: begin
				end
			endcase
		end
	end

endmodule

// File: rtl/cpuDefs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path and instruction word width
`define DATA_W 16

// Unified memory depth in 16-bit words
`define MEM_WORDS 512

// Byte address of the first fetch
`define RESET_PC 16'h0000

`endif

// File: rtl/cpuFsm.sv
module cpuFsm (
	input  logic clk,
	input  logic rstN,
	input  logic memRead,
	input  logic memWrite,
	input  logic regWrite,
	input  logic aluOp,
	input  logic hlt,
	input  logic branch,
	input  logic branchReg,
	output logic irLoad,
	output logic dataPhase,
	output logic memWe,
	output logic regWe,
	output logic flagWe,
	output logic pcStep,
	output logic pcBranch,
	output logic halted
);

	cpuPkg::stateT state;
	cpuPkg::stateT nextState;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= cpuPkg::FETCH;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			cpuPkg::FETCH:  nextState = cpuPkg::DECODE;
			cpuPkg::DECODE: nextState = cpuPkg::EXEC;
			cpuPkg::EXEC: begin
				if (memRead || memWrite)
					nextState = cpuPkg::MEM;
				else if (hlt)
					nextState = cpuPkg::HALTED;
				else if (regWrite)
					nextState = cpuPkg::WB;
				else
					nextState = cpuPkg::FETCH;
			end
			// Only loads carry on to writeback
			cpuPkg::MEM:    nextState = memRead ? cpuPkg::WB : cpuPkg::FETCH;
			cpuPkg::WB:     nextState = cpuPkg::FETCH;
			cpuPkg::HALTED: nextState = cpuPkg::HALTED;
			default:        nextState = cpuPkg::FETCH;
		endcase
	end

	// Instruction word arrives from memory one cycle after FETCH
	assign irLoad    = (state == cpuPkg::DECODE);
	assign pcStep    = (state == cpuPkg::DECODE);
	assign dataPhase = (state == cpuPkg::EXEC) || (state == cpuPkg::MEM);
	assign memWe     = (state == cpuPkg::MEM) && memWrite;
	assign regWe     = (state == cpuPkg::WB) && regWrite;
	assign flagWe    = (state == cpuPkg::EXEC) && aluOp;
	assign pcBranch  = (state == cpuPkg::EXEC) && (branch || branchReg);
	assign halted    = (state == cpuPkg::HALTED);

	noRegMemWe: assert property (@(posedge clk) disable iff (!rstN) !(regWe && memWe));

	// Halt is sticky and silent
	haltQuiet: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted && !(regWe || memWe || flagWe || pcStep || pcBranch || irLoad));

endmodule

// File: rtl/cpuPkg.sv
package cpuPkg;

	typedef enum logic [3:0] {
		ADD    = 4'h0,
		SUB    = 4'h1,
		RED    = 4'h2,
		XOR    = 4'h3,
		SLL    = 4'h4,
		SRA    = 4'h5,
		ROR    = 4'h6,
		PADDSB = 4'h7,
		LW     = 4'h8,
		SW     = 4'h9,
		LHB    = 4'hA,
		LLB    = 4'hB,
		B      = 4'hC,
		BR     = 4'hD,
		PCS    = 4'hE,
		HLT    = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {
		NE = 3'd0,
		EQ = 3'd1,
		GT = 3'd2,
		LT = 3'd3,
		GE = 3'd4,
		LE = 3'd5,
		OV = 3'd6,
		UN = 3'd7
	} condT;

	// Same word seen as register, immediate and branch formats
	typedef union packed {
		struct packed {
			opcodeT     opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt;
		} rType;
		struct packed {
			opcodeT     opcode;
			logic [3:0] rd;
			logic [7:0] imm;
		} iType;
		struct packed {
			opcodeT     opcode;
			condT       cond;
			logic [8:0] offset;
		} bType;
	} instrT;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXEC,
		MEM,
		WB,
		HALTED
	} stateT;

endpackage

// File: rtl/cpuTop.sv
`include "cpuDefs.svh"

module cpuTop (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          progWe,
	input  logic [$clog2(`MEM_WORDS)-1:0] progAddr,
	input  logic [`DATA_W-1:0]            progData,
	output logic                          halted,
	output logic                          wbEn,
	output logic [3:0]                    wbReg,
	output logic [`DATA_W-1:0]            wbData,
	output logic [`DATA_W-1:0]            pc
);

	cpuPkg::instrT      instr;
	logic               memRead;
	logic               memWrite;
	logic               memToReg;
	logic               regWrite;
	logic               aluOp;
	logic               aluImm;
	logic               pcs;
	logic               llb;
	logic               lhb;
	logic               hlt;
	logic               branch;
	logic               branchReg;
	logic               irLoad;
	logic               dataPhase;
	logic               memWe;
	logic               regWe;
	logic               flagWe;
	logic               pcStep;
	logic               pcBranch;
	logic               flagZ;
	logic               flagV;
	logic               flagN;
	logic [3:0]         rdAddrB;
	logic [`DATA_W-1:0] rdDataA;
	logic [`DATA_W-1:0] rdDataB;
	logic [`DATA_W-1:0] aluResult;
	logic [`DATA_W-1:0] memRdData;

	// Stores and byte loads read rd on port B
	assign rdAddrB = (memWrite || llb || lhb) ? instr.rType.rd : instr.rType.rt;
	assign wbData  = memToReg ? memRdData : aluResult;
	assign wbReg   = instr.rType.rd;
	assign wbEn    = regWe;

	ctrlUnit u_ctrl (
		.clk(clk), .rstN(rstN), .irLoad(irLoad), .memData(memRdData), .instr(instr),
		.memRead(memRead), .memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite),
		.aluOp(aluOp), .aluImm(aluImm), .pcs(pcs), .llb(llb), .lhb(lhb), .hlt(hlt),
		.branch(branch), .branchReg(branchReg)
	);

	cpuFsm u_fsm (
		.clk(clk), .rstN(rstN), .memRead(memRead), .memWrite(memWrite),
		.regWrite(regWrite), .aluOp(aluOp), .hlt(hlt), .branch(branch),
		.branchReg(branchReg), .irLoad(irLoad), .dataPhase(dataPhase), .memWe(memWe),
		.regWe(regWe), .flagWe(flagWe), .pcStep(pcStep), .pcBranch(pcBranch),
		.halted(halted)
	);

	pcCounter u_pc (
		.clk(clk), .rstN(rstN), .instr(instr), .pcStep(pcStep), .pcBranch(pcBranch),
		.branchReg(branchReg), .flagZ(flagZ), .flagV(flagV), .flagN(flagN),
		.regA(rdDataA), .pc(pc)
	);

	regFile u_rf (
		.clk(clk), .rstN(rstN), .rdAddrA(instr.rType.rs), .rdAddrB(rdAddrB),
		.wrAddr(instr.rType.rd), .we(regWe), .wrData(wbData),
		.rdDataA(rdDataA), .rdDataB(rdDataB)
	);

	alu u_alu (
		.clk(clk), .rstN(rstN), .instr(instr), .aluOp(aluOp), .aluImm(aluImm),
		.pcs(pcs), .llb(llb), .lhb(lhb), .flagWe(flagWe), .opA(rdDataA), .opB(rdDataB),
		.pc(pc), .result(aluResult), .flagZ(flagZ), .flagV(flagV), .flagN(flagN)
	);

	memory u_mem (
		.clk(clk), .dataPhase(dataPhase), .pc(pc), .dataAddr(aluResult), .we(memWe),
		.wrData(rdDataB), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.rdData(memRdData)
	);

endmodule

// File: rtl/ctrlUnit.sv
`include "cpuDefs.svh"

module ctrlUnit (
	input  logic                clk,
	input  logic                rstN,
	input  logic                irLoad,
	input  logic [`DATA_W-1:0]  memData,
	output cpuPkg::instrT       instr,
	output logic                memRead,
	output logic                memWrite,
	output logic                memToReg,
	output logic                regWrite,
	output logic                aluOp,
	output logic                aluImm,
	output logic                pcs,
	output logic                llb,
	output logic                lhb,
	output logic                hlt,
	output logic                branch,
	output logic                branchReg
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instr <= '0;
		end else if (irLoad) begin
			instr <= memData;
		end
	end

	// Upper half of the opcode space does not use the ALU function
	assign aluOp     = ~instr.rType.opcode[3];
	assign lhb       = (instr.rType.opcode == cpuPkg::LHB);
	assign llb       = (instr.rType.opcode == cpuPkg::LLB);
	assign pcs       = (instr.rType.opcode == cpuPkg::PCS);
	assign hlt       = (instr.rType.opcode == cpuPkg::HLT);
	assign branch    = (instr.rType.opcode == cpuPkg::B);
	assign branchReg = (instr.rType.opcode == cpuPkg::BR);

	always_comb begin
		memRead  = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		aluImm   = 1'b0;
		case (instr.rType.opcode)
			cpuPkg::ADD, cpuPkg::SUB, cpuPkg::RED, cpuPkg::XOR, cpuPkg::PADDSB, cpuPkg::PCS: begin
				regWrite = 1'b1;
			end
			cpuPkg::SLL, cpuPkg::SRA, cpuPkg::ROR, cpuPkg::LHB, cpuPkg::LLB: begin
				regWrite = 1'b1;
				aluImm   = 1'b1;
			end
			cpuPkg::LW: begin
				memRead  = 1'b1;
				memToReg = 1'b1;
				regWrite = 1'b1;
			end
			cpuPkg::SW: begin
				memWrite = 1'b1;
			end
			// B, BR and HLT write nothing
			default: begin
			end
		endcase
	end

	noMemRdWr: assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite));

endmodule

// File: rtl/memory.sv
`include "cpuDefs.svh"

module memory (
	input  logic                         clk,
	input  logic                         dataPhase,
	input  logic [`DATA_W-1:0]           pc,
	input  logic [`DATA_W-1:0]           dataAddr,
	input  logic                         we,
	input  logic [`DATA_W-1:0]           wrData,
	input  logic                         progWe,
	input  logic [$clog2(`MEM_WORDS)-1:0] progAddr,
	input  logic [`DATA_W-1:0]           progData,
	output logic [`DATA_W-1:0]           rdData
);

	localparam int AddrW = $clog2(`MEM_WORDS);

	logic [`DATA_W-1:0] mem [`MEM_WORDS];
	logic [AddrW-1:0]   addr;

	// Byte addresses in, word index out
	assign addr = dataPhase ? dataAddr[AddrW:1] : pc[AddrW:1];

	always_ff @(posedge clk) begin
		if (progWe)
			mem[progAddr] <= progData;
		else if (we)
			mem[addr] <= wrData;
		rdData <= mem[addr];
	end

	noProgCollide: assert property (@(posedge clk) !(progWe && we));

endmodule

// File: rtl/pcCounter.sv
`include "cpuDefs.svh"

module pcCounter (
	input  logic               clk,
	input  logic               rstN,
	input  cpuPkg::instrT      instr,
	input  logic               pcStep,
	input  logic               pcBranch,
	input  logic               branchReg,
	input  logic               flagZ,
	input  logic               flagV,
	input  logic               flagN,
	input  logic [`DATA_W-1:0] regA,
	output logic [`DATA_W-1:0] pc
);

	logic               taken;
	logic               gt;
	logic [`DATA_W-1:0] target;

	assign gt = !flagZ && !flagN;

	always_comb begin
		case (instr.bType.cond)
			cpuPkg::NE: taken = !flagZ;
			cpuPkg::EQ: taken = flagZ;
			cpuPkg::GT: taken = gt;
			cpuPkg::LT: taken = flagN;
			cpuPkg::GE: taken = gt || flagZ;
			cpuPkg::LE: taken = flagN || flagZ;
			cpuPkg::OV: taken = flagV;
			default:    taken = 1'b1;
		endcase
	end

	// Offset counts words relative to the stepped PC
	assign target = branchReg ? {regA[`DATA_W-1:1], 1'b0} :
		pc + {{(`DATA_W-10){instr.bType.offset[8]}}, instr.bType.offset, 1'b0};

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (pcStep) begin
			pc <= pc + `DATA_W'd2;
		end else if (pcBranch && taken) begin
			pc <= target;
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[0] == 1'b0);

endmodule

// File: rtl/regFile.sv
`include "cpuDefs.svh"

module regFile (
	input  logic               clk,
	input  logic               rstN,
	input  logic [3:0]         rdAddrA,
	input  logic [3:0]         rdAddrB,
	input  logic [3:0]         wrAddr,
	input  logic               we,
	input  logic [`DATA_W-1:0] wrData,
	output logic [`DATA_W-1:0] rdDataA,
	output logic [`DATA_W-1:0] rdDataB
);

	logic [`DATA_W-1:0] regs [16];

	// R0 keeps its reset value because writes to it are dropped
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wrAddr != 4'd0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f project.f -o cpuSim

./obj_dir/cpuSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// File: verification/cpuTb.sv
`include "cpuDefs.svh"

module cpuTb;

	localparam int AddrW = $clog2(`MEM_WORDS);

	logic               clk;
	logic               rstN;
	logic               progWe;
	logic [AddrW-1:0]   progAddr;
	logic [`DATA_W-1:0] progData;
	logic               halted;
	logic               wbEn;
	logic [3:0]         wbReg;
	logic [`DATA_W-1:0] wbData;
	logic [`DATA_W-1:0] pc;

	// Program words in memory order, and the writeback trace they produce
	logic [15:0] progWords [$];
	logic [3:0]  expReg [$];
	logic [15:0] expVal [$];

	// Architectural state tracked while the table is built
	logic [15:0] shadow [16];
	logic [15:0] dataMem [int];
	logic        fZ;
	logic        fV;
	logic        fN;
	int          skip;
	logic [31:0] rngState;

	int          cycles;
	int          limit;
	int          wbCount;
	logic [15:0] haltPc;

	cpuTop dut0 (
		.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.halted(halted), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .pc(pc)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic logic [7:0] nextImm();
		rngState = xorshift(rngState);
		return rngState[7:0];
	endfunction

	// Clip to the signed 16-bit range
	function automatic logic [15:0] clip16(input int s);
		if (s > 32767)
			return 16'h7FFF;
		if (s < -32768)
			return 16'h8000;
		return s[15:0];
	endfunction

	function automatic logic [15:0] byteSum(input logic [15:0] a, input logic [15:0] b);
		byte p0;
		byte p1;
		byte p2;
		byte p3;
		int  s;
		p0 = a[15:8];
		p1 = a[7:0];
		p2 = b[15:8];
		p3 = b[7:0];
		s = int'(p0) + int'(p1) + int'(p2) + int'(p3);
		return s[15:0];
	endfunction

	function automatic logic [15:0] nibbleAdd(input logic [15:0] a, input logic [15:0] b);
		logic [15:0] r;
		int          s;
		for (int i = 0; i < 4; i++) begin
			s = int'($signed(a[4*i +: 4])) + int'($signed(b[4*i +: 4]));
			if (s > 7)
				s = 7;
			else if (s < -8)
				s = -8;
			r[4*i +: 4] = s[3:0];
		end
		return r;
	endfunction

	function automatic logic [15:0] rotRight(input logic [15:0] a, input int n);
		logic [31:0] d;
		d = {a, a} >> n;
		return d[15:0];
	endfunction

	function automatic bit condMet(input logic [2:0] c);
		case (c)
			cpuPkg::NE: return !fZ;
			cpuPkg::EQ: return fZ;
			cpuPkg::GT: return !fZ && !fN;
			cpuPkg::LT: return fN;
			cpuPkg::GE: return (!fZ && !fN) || fZ;
			cpuPkg::LE: return fN || fZ;
			cpuPkg::OV: return fV;
			default:    return 1'b1;
		endcase
	endfunction

	// Words inside a taken branch's shadow are stored but never run
	task automatic place(input logic [15:0] w, output bit live);
		progWords.push_back(w);
		live = (skip == 0);
		if (!live)
			skip--;
	endtask

	task automatic retire(input logic [3:0] rd, input logic [15:0] v);
		expReg.push_back(rd);
		expVal.push_back(v);
		if (rd != 4'd0)
			shadow[rd] = v;
	endtask

	task automatic aluInstr(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs,
		input logic [3:0] rt);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] r;
		int          s;
		bit          live;
		place({op, rd, rs, rt}, live);
		if (live) begin
			a = shadow[rs];
			b = shadow[rt];
			s = 0;
			if (op == cpuPkg::ADD)
				s = int'($signed(a)) + int'($signed(b));
			else if (op == cpuPkg::SUB)
				s = int'($signed(a)) - int'($signed(b));
			case (op)
				cpuPkg::ADD, cpuPkg::SUB: r = clip16(s);
				cpuPkg::RED:              r = byteSum(a, b);
				cpuPkg::XOR:              r = a ^ b;
				cpuPkg::SLL:              r = a << rt;
				cpuPkg::SRA:              r = $signed(a) >>> rt;
				cpuPkg::ROR:              r = rotRight(a, rt);
				default:                  r = nibbleAdd(a, b);
			endcase
			if (op == cpuPkg::ADD || op == cpuPkg::SUB) begin
				fV = (s > 32767) || (s < -32768);
				fN = r[15];
			end
			if (op inside {cpuPkg::ADD, cpuPkg::SUB, cpuPkg::XOR, cpuPkg::SLL, cpuPkg::SRA,
				cpuPkg::ROR})
				fZ = (r == 16'h0000);
			retire(rd, r);
		end
	endtask

	task automatic byteInstr(input logic [3:0] op, input logic [3:0] rd, input logic [7:0] imm);
		bit live;
		place({op, rd, imm}, live);
		if (live) begin
			if (op == cpuPkg::LLB)
				retire(rd, {shadow[rd][15:8], imm});
			else
				retire(rd, {imm, shadow[rd][7:0]});
		end
	endtask

	task automatic memInstr(input logic [3:0] op, input logic [3:0] rd, input logic [3:0] rs,
		input logic signed [3:0] off);
		int          ea;
		logic [15:0] addr;
		bit          live;
		place({op, rd, rs, off}, live);
		if (live) begin
			ea = int'(shadow[rs]) + 2 * int'(off);
			addr = ea[15:0];
			if (op == cpuPkg::SW)
				dataMem[addr] = shadow[rd];
			else
				retire(rd, dataMem[addr]);
		end
	endtask

	task automatic branchInstr(input logic [2:0] cond, input logic [8:0] offset);
		bit live;
		place({cpuPkg::B, cond, offset}, live);
		if (live && condMet(cond))
			skip = offset;
	endtask

	task automatic branchRegInstr(input logic [2:0] cond, input logic [3:0] rs);
		int next;
		bit live;
		next = 2 * progWords.size() + 2;
		place({cpuPkg::BR, cond, 1'b0, rs, 4'h0}, live);
		if (live && condMet(cond))
			skip = (int'(shadow[rs]) - next) / 2;
	endtask

	task automatic pcsInstr(input logic [3:0] rd);
		logic [15:0] here;
		bit          live;
		here = 16'(2 * progWords.size());
		place({cpuPkg::PCS, rd, 8'h00}, live);
		if (live)
			retire(rd, here + 16'd2);
	endtask

	task automatic buildProgram();
		rngState = 32'd33;
		skip = 0;
		fZ = 1'b0;
		fV = 1'b0;
		fN = 1'b0;
		foreach (shadow[i])
			shadow[i] = '0;
		for (int r = 1; r <= 4; r++) begin
			byteInstr(cpuPkg::LLB, 4'(r), nextImm());
			byteInstr(cpuPkg::LHB, 4'(r), nextImm());
		end
		// R0 write is dropped and r5 reads back zero
		byteInstr(cpuPkg::LLB, 4'd0, nextImm());
		aluInstr(cpuPkg::ADD, 4'd5, 4'd0, 4'd0);
		byteInstr(cpuPkg::LLB, 4'd6, nextImm());
		byteInstr(cpuPkg::LHB, 4'd6, 8'h70);
		byteInstr(cpuPkg::LLB, 4'd8, nextImm());
		byteInstr(cpuPkg::LHB, 4'd8, 8'h90);
		// All four of these clip
		aluInstr(cpuPkg::ADD, 4'd7, 4'd6, 4'd6);
		aluInstr(cpuPkg::ADD, 4'd9, 4'd8, 4'd8);
		aluInstr(cpuPkg::SUB, 4'd10, 4'd6, 4'd8);
		aluInstr(cpuPkg::SUB, 4'd11, 4'd8, 4'd6);
		aluInstr(cpuPkg::ADD, 4'd12, 4'd1, 4'd2);
		aluInstr(cpuPkg::SUB, 4'd13, 4'd3, 4'd4);
		aluInstr(cpuPkg::XOR, 4'd14, 4'd1, 4'd3);
		aluInstr(cpuPkg::RED, 4'd15, 4'd2, 4'd4);
		aluInstr(cpuPkg::PADDSB, 4'd12, 4'd1, 4'd4);
		aluInstr(cpuPkg::PADDSB, 4'd13, 4'd7, 4'd8);
		aluInstr(cpuPkg::SLL, 4'd13, 4'd1, 4'd3);
		aluInstr(cpuPkg::SRA, 4'd14, 4'd8, 4'd5);
		aluInstr(cpuPkg::SRA, 4'd15, 4'd2, 4'd9);
		aluInstr(cpuPkg::ROR, 4'd12, 4'd3, 4'd7);
		aluInstr(cpuPkg::ROR, 4'd13, 4'd4, 4'd12);
		aluInstr(cpuPkg::SLL, 4'd14, 4'd2, 4'd15);
		// Data area at 0x0310 sits well above the program
		byteInstr(cpuPkg::LLB, 4'd5, 8'h10);
		byteInstr(cpuPkg::LHB, 4'd5, 8'h03);
		memInstr(cpuPkg::SW, 4'd1, 4'd5, 4'sd3);
		memInstr(cpuPkg::SW, 4'd2, 4'd5, -4'sd2);
		memInstr(cpuPkg::LW, 4'd9, 4'd5, 4'sd3);
		memInstr(cpuPkg::LW, 4'd10, 4'd5, -4'sd2);
		aluInstr(cpuPkg::SUB, 4'd11, 4'd1, 4'd1);
		branchInstr(cpuPkg::EQ, 9'd1);
		aluInstr(cpuPkg::ADD, 4'd12, 4'd1, 4'd1);
		branchInstr(cpuPkg::NE, 9'd1);
		aluInstr(cpuPkg::ADD, 4'd13, 4'd2, 4'd0);
		branchInstr(cpuPkg::UN, 9'd2);
		byteInstr(cpuPkg::LLB, 4'd3, nextImm());
		byteInstr(cpuPkg::LLB, 4'd4, nextImm());
		// BR target is the PCS result plus 8 bytes
		aluInstr(cpuPkg::SUB, 4'd6, 4'd6, 4'd6);
		byteInstr(cpuPkg::LLB, 4'd6, 8'h08);
		pcsInstr(4'd7);
		aluInstr(cpuPkg::ADD, 4'd8, 4'd7, 4'd6);
		branchRegInstr(cpuPkg::UN, 4'd8);
		byteInstr(cpuPkg::LLB, 4'd9, nextImm());
		byteInstr(cpuPkg::LLB, 4'd10, nextImm());
		aluInstr(cpuPkg::XOR, 4'd11, 4'd8, 4'd7);
		pcsInstr(4'd12);
		progWords.push_back({cpuPkg::HLT, 12'h000});
	endtask

	task automatic checkValue(input string what, input logic [15:0] got, input logic [15:0] want);
		if (got !== want) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
			$display("Finished with errors");
			$fatal(1, "value mismatch");
		end
	endtask

	initial begin
		rstN = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		cycles = 0;
		wbCount = 0;
		buildProgram();
		limit = 5 * progWords.size() + 40;
		foreach (progWords[i]) begin
			@(negedge clk);
			progWe = 1'b1;
			progAddr = AddrW'(i);
			progData = progWords[i];
		end
		@(negedge clk);
		progWe = 1'b0;
		repeat (3) @(negedge clk);
		rstN = 1'b1;

		while (!halted) begin
			@(negedge clk);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: the program never halted within %0d cycles", limit);
				$display("Finished with errors");
				$fatal(1, "timeout");
			end
			if (wbEn) begin
				if (wbCount >= expReg.size()) begin
					$display("A register write appeared past the end of the trace at %0t", $time);
					$display("Finished with errors");
					$fatal(1, "extra writeback");
				end
				checkValue($sformatf("writeback %0d register", wbCount), 16'(wbReg),
					16'(expReg[wbCount]));
				checkValue($sformatf("writeback %0d data", wbCount), wbData, expVal[wbCount]);
				wbCount++;
			end
		end

		// Core must stay frozen once halted
		haltPc = pc;
		repeat (10) begin
			@(negedge clk);
			checkValue("halted", 16'(halted), 16'h0001);
			checkValue("wbEn after halt", 16'(wbEn), 16'h0000);
			checkValue("pc after halt", pc, haltPc);
		end
		checkValue("writeback count", 16'(wbCount), 16'(expReg.size()));
		$display("Finished with no errors");
		$finish;
	end

endmodule
